// ==== rtl/vgaPkg.sv ====
package vgaPkg;

	// channel and counter widths
	localparam int COLOR_W = 10;
	localparam int COUNT_W = 10;

	// horizontal timing, in pixel clocks
	localparam int H_SYNC_CYC  = 96;
	localparam int H_SYNC_BACK = 45;
	localparam int H_ACT       = 640;
	localparam int H_TOTAL     = 800;

	// vertical timing, in lines
	localparam int V_SYNC_CYC  = 2;
	localparam int V_SYNC_BACK = 32;
	localparam int V_ACT       = 480;
	localparam int V_TOTAL     = 525;

	// first visible column, four clocks past the back porch
	localparam int X_START = H_SYNC_CYC + H_SYNC_BACK + 4;
	// first visible row
	localparam int Y_START = V_SYNC_CYC + V_SYNC_BACK;

	// request opens this many columns ahead of the pixel
	localparam int REQ_LEAD = 2;

	// outer frame, offsets from the active window origin
	localparam int FRAME_LEFT   = 170;
	localparam int FRAME_RIGHT  = 469;
	localparam int FRAME_TOP    = 165;
	localparam int FRAME_BOTTOM = 314;
	localparam int FRAME_THICK  = 2;

	// candidate rectangles, one pixel thick
	localparam int NUM_RECT = 5;
	// left edges, rectangle 1 first
	localparam int RECT_LEFT [NUM_RECT] = '{174, 223, 272, 321, 370};
	localparam int RECT_WIDTH  = 95;
	localparam int RECT_TOP    = 169;
	localparam int RECT_BOTTOM = 310;

	// output levels
	localparam logic [COLOR_W-1:0] OVERLAY_LEVEL   = 10'h1FF;
	localparam logic [COLOR_W-1:0] SHADE_HIGH      = 10'h3FF;
	localparam logic [COLOR_W-1:0] SHADE_THRESHOLD = 10'h180;

	// bit 4 is rectangle 1, bit 0 rectangle 5
	typedef logic [NUM_RECT-1:0] rectMask_t;

	typedef struct packed {
		logic [COUNT_W-1:0] hCount;
		logic [COUNT_W-1:0] vCount;
	} scanPos_t;

	typedef struct packed {
		logic [COLOR_W-1:0] r;
		logic [COLOR_W-1:0] g;
		logic [COLOR_W-1:0] b;
	} rgbPixel_t;

	// selection input to drawn rectangles
	// overlapping neighbours drop to the pattern the calc block expects
	localparam rectMask_t RECT_SEL_TABLE [32] = '{
		// 00000 .. 00111
		5'b00000, 5'b00001, 5'b00010, 5'b00010,
		5'b00100, 5'b00101, 5'b00100, 5'b00101,
		// 01000 .. 01111
		5'b01000, 5'b01001, 5'b01010, 5'b01010,
		5'b00100, 5'b00101, 5'b01010, 5'b01010,
		// 10000 .. 10111
		5'b10000, 5'b10001, 5'b10010, 5'b10010,
		5'b10100, 5'b10101, 5'b10100, 5'b10101,
		// 11000 .. 11111
		5'b01000, 5'b01001, 5'b01010, 5'b01010,
		5'b10100, 5'b10101, 5'b01010, 5'b10101
	};

endpackage

// ==== rtl/vgaTiming.sv ====
`timescale 1ns/1ps

module vgaTiming
(
	input  logic             iCLK,
	input  logic             iRST_N,
	output vgaPkg::scanPos_t scanPos,
	output logic             hSync,
	output logic             vSync,
	output logic             blank,
	output logic             request
);
	import vgaPkg::*;

	logic [COUNT_W-1:0] hCount;
	logic [COUNT_W-1:0] vCount;
	logic               reqCol;
	logic               reqRow;

	// horizontal counter, 0..H_TOTAL inclusive
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			hCount <= '0;
			hSync  <= 1'b0;
		end
		else
		begin
			if (hCount < H_TOTAL)
				hCount <= hCount + 1'b1;
			else
				hCount <= '0;
			// sync low during the first H_SYNC_CYC columns, one clock late
			if (hCount < H_SYNC_CYC)
				hSync <= 1'b0;
			else
				hSync <= 1'b1;
		end
	end

	// vertical counter steps once per line, at column 0
	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
		begin
			vCount <= '0;
			vSync  <= 1'b0;
		end
		else if (hCount == '0)
		begin
			if (vCount < V_TOTAL)
				vCount <= vCount + 1'b1;
			else
				vCount <= '0;
			// sync from the row before the step
			if (vCount < V_SYNC_CYC)
				vSync <= 1'b0;
			else
				vSync <= 1'b1;
		end
	end

	// request window, shifted left by REQ_LEAD so the host has time
	assign reqCol = (hCount >= X_START - REQ_LEAD) && (hCount < X_START + H_ACT - REQ_LEAD);
	assign reqRow = (vCount >= Y_START) && (vCount < Y_START + V_ACT);

	always_ff @(posedge iCLK or negedge iRST_N)
	begin
		if (!iRST_N)
			request <= 1'b0;
		else
			request <= reqCol && reqRow;
	end

	assign scanPos = '{hCount: hCount, vCount: vCount};

	// composite blank, high only when both syncs are inactive
	assign blank = hSync & vSync;

endmodule

// ==== rtl/rectOverlay.sv ====
`timescale 1ns/1ps

module rectOverlay
(
	input  vgaPkg::scanPos_t  scanPos,
	input  vgaPkg::rectMask_t rectSel,
	output logic              overlayHit
);
	import vgaPkg::*;

	// absolute frame bounds
	localparam int FL = X_START + FRAME_LEFT;
	localparam int FR = X_START + FRAME_RIGHT;
	localparam int FT = Y_START + FRAME_TOP;
	localparam int FB = Y_START + FRAME_BOTTOM;

	// rectangle rows, common to all five
	localparam int RT = Y_START + RECT_TOP;
	localparam int RB = Y_START + RECT_BOTTOM;

	logic [COUNT_W-1:0] hCount;
	logic [COUNT_W-1:0] vCount;
	logic               frameCol;
	logic               frameRow;
	logic               frameHSpan;
	logic               frameVSpan;
	logic               frameHit;
	rectMask_t          rectHit;
	rectMask_t          rectShown;

	assign hCount = scanPos.hCount;
	assign vCount = scanPos.vCount;

	// frame extent, inclusive on all sides
	assign frameHSpan = (hCount >= FL) && (hCount <= FR);
	assign frameVSpan = (vCount >= FT) && (vCount <= FB);

	// two outermost columns at each side
	assign frameCol = ((hCount >= FL) && (hCount < FL + FRAME_THICK)) ||
		((hCount > FR - FRAME_THICK) && (hCount <= FR));

	// two outermost rows at top and bottom
	assign frameRow = ((vCount >= FT) && (vCount < FT + FRAME_THICK)) ||
		((vCount > FB - FRAME_THICK) && (vCount <= FB));

	assign frameHit = (frameCol && frameVSpan) || (frameRow && frameHSpan);

	// one boundary detector per candidate
	for (genvar i = 0; i < NUM_RECT; i++)
	begin : genRect
		localparam int RL = X_START + RECT_LEFT[i];
		localparam int RR = RL + RECT_WIDTH;

		logic onCol;
		logic onRow;
		logic hSpan;
		logic vSpan;

		assign onCol = (hCount == RL) || (hCount == RR);
		assign onRow = (vCount == RT) || (vCount == RB);
		assign hSpan = (hCount >= RL) && (hCount <= RR);
		assign vSpan = (vCount >= RT) && (vCount <= RB);

		// rectangle 1 lands on the top mask bit
		assign rectHit[NUM_RECT-1-i] = (onCol && vSpan) || (onRow && hSpan);
	end

	// table lookup, filters out clashing neighbours
	assign rectShown = RECT_SEL_TABLE[rectSel];

	// frame is always drawn
	assign overlayHit = frameHit || (|(rectHit & rectShown));

endmodule

// ==== rtl/pixelCompose.sv ====
`timescale 1ns/1ps

module pixelCompose
(
	input  vgaPkg::scanPos_t            scanPos,
	input  logic [vgaPkg::COLOR_W-1:0]  hostBlue,
	input  logic                        overlayHit,
	output vgaPkg::rgbPixel_t           vgaColor
);
	import vgaPkg::*;

	logic               inWindow;
	logic               bright;
	logic [COLOR_W-1:0] shade;
	logic [COLOR_W-1:0] level;

	// visible 640x480 area
	assign inWindow = (scanPos.hCount >= X_START) && (scanPos.hCount < X_START + H_ACT) &&
		(scanPos.vCount >= Y_START) && (scanPos.vCount < Y_START + V_ACT);

	// strict compare, threshold itself stays black
	assign bright = hostBlue > SHADE_THRESHOLD;

	// black or white only, black in the porches
	assign shade = (inWindow && bright) ? SHADE_HIGH : '0;

	// overlay wins over the camera shade
	assign level = overlayHit ? OVERLAY_LEVEL : shade;

	// grey scale, same level on every channel
	assign vgaColor = '{r: level, g: level, b: level};

endmodule

// ==== rtl/vgaController.sv ====
`timescale 1ns/1ps

module vgaController
(
	input  logic                        iCLK,
	input  logic                        iRST_N,
	// host side
	input  vgaPkg::rectMask_t           rectSel,
	input  logic [vgaPkg::COLOR_W-1:0]  hostBlue,
	output logic                        request,
	output vgaPkg::scanPos_t            scanPos,
	// display side
	output vgaPkg::rgbPixel_t           vgaColor,
	output logic                        hSync,
	output logic                        vSync,
	output logic                        blank
);

	// frame or selected rectangle under the beam
	logic overlayHit;

	// scan counters and registered syncs
	vgaTiming timing_i
	(
		.iCLK    (iCLK),
		.iRST_N  (iRST_N),
		.scanPos (scanPos),
		.hSync   (hSync),
		.vSync   (vSync),
		.blank   (blank),
		.request (request)
	);

	// boundary detection, same cycle as scanPos
	rectOverlay overlay_i
	(
		.scanPos    (scanPos),
		.rectSel    (rectSel),
		.overlayHit (overlayHit)
	);

	// final colour, combinational from position and host data
	pixelCompose compose_i
	(
		.scanPos    (scanPos),
		.hostBlue   (hostBlue),
		.overlayHit (overlayHit),
		.vgaColor   (vgaColor)
	);

endmodule

// ==== tb/vgaTiming_asserts.sv ====
`timescale 1ns/1ps

module vgaTimingAsserts
(
	input logic                       iCLK,
	input logic                       iRST_N,
	input logic [vgaPkg::COUNT_W-1:0] hCount,
	input logic [vgaPkg::COUNT_W-1:0] vCount,
	input logic                       hSync
);
	import vgaPkg::*;

	// line counter never runs past its last column
	hCountRange: assert property (@(posedge iCLK) disable iff (!iRST_N) hCount <= H_TOTAL)
		else $error("hCount above H_TOTAL");

	// row steps only at column 0
	vCountStep: assert property (@(posedge iCLK) disable iff (!iRST_N)
		(hCount != '0) |=> $stable(vCount))
		else $error("vCount changed away from column 0");

	// sync one clock behind the column compare
	hSyncLate: assert property (@(posedge iCLK) disable iff (!iRST_N)
		1'b1 |=> (hSync == ($past(hCount) >= H_SYNC_CYC)))
		else $error("hSync does not follow the previous hCount");

endmodule

bind vgaTiming vgaTimingAsserts timingAsserts_i
(
	.iCLK   (iCLK),
	.iRST_N (iRST_N),
	.hCount (hCount),
	.vCount (vCount),
	.hSync  (hSync)
);

// ==== tb/vgaControllerTb.sv ====
`timescale 1ns/1ps

module vgaControllerTb;

	// own copy of the display timing
	localparam int H_TOTAL    = 800;
	localparam int V_TOTAL    = 525;
	localparam int H_SYNC_CYC = 96;
	localparam int V_SYNC_CYC = 2;
	localparam int H_ACT      = 640;
	localparam int V_ACT      = 480;
	localparam int X0         = 145;
	localparam int Y0         = 34;
	localparam int LEAD       = 2;
	// frame and rectangles in absolute scan coordinates
	localparam int FRAME_L = X0 + 170;
	localparam int FRAME_R = X0 + 469;
	localparam int FRAME_T = Y0 + 165;
	localparam int FRAME_B = Y0 + 314;
	localparam int RECT_T  = Y0 + 169;
	localparam int RECT_B  = Y0 + 310;
	localparam int RECT_W  = 95;
	localparam int RECT_X [5] = '{X0 + 174, X0 + 223, X0 + 272, X0 + 321, X0 + 370};
	localparam logic [9:0] OVERLAY   = 10'h1FF;
	localparam logic [9:0] WHITE     = 10'h3FF;
	localparam logic [9:0] THRESHOLD = 10'h180;
	// three frames of 801 x 526 clocks
	localparam int CYCLE_LIMIT = 3 * 801 * 526;
	// selections under test and what each one should draw
	localparam logic [4:0] SEL_IN [5]    = '{5'b10000, 5'b11000, 5'b01010, 5'b10101, 5'b00011};
	localparam logic [4:0] SEL_DRAWN [5] = '{5'b10000, 5'b01000, 5'b01010, 5'b10101, 5'b00010};

	logic        iCLK;
	logic        iRST_N;
	logic [4:0]  rectSel;
	logic [9:0]  hostBlue;
	logic [29:0] vgaColor;
	logic [19:0] scanPos;
	logic        hSync;
	logic        vSync;
	logic        blank;
	logic        request;

	int          errors;
	int          checks;
	int          cycles;
	logic [31:0] lcgState;
	// scan position at this sample and at the one before
	logic [9:0]  curH;
	logic [9:0]  curV;
	logic [9:0]  prevH;
	logic [9:0]  prevV;

	vgaController dut_i
	(
		.iCLK     (iCLK),
		.iRST_N   (iRST_N),
		.rectSel  (rectSel),
		.hostBlue (hostBlue),
		.request  (request),
		.scanPos  (scanPos),
		.vgaColor (vgaColor),
		.hSync    (hSync),
		.vSync    (vSync),
		.blank    (blank)
	);

	initial
	begin
		iCLK = 1'b0;
		forever #5 iCLK = ~iCLK;
	end

	// run limit
	initial
	begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT)
		begin
			@(posedge iCLK);
			cycles++;
		end
		$display("Timeout: tests did not finish within %0d clock cycles", CYCLE_LIMIT);
		$display("Verification failed");
		$finish;
	end

	function automatic logic [31:0] lcgStep(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic randomBlue(output logic [9:0] blue);
		lcgState = lcgStep(lcgState);
		blue = lcgState[25:16];
	endtask

	// drive just after the rising edge and sample at the falling edge
	task automatic advance(input logic [4:0] sel, input logic [9:0] blue);
		prevH = curH;
		prevV = curV;
		@(posedge iCLK);
		#1;
		rectSel  = sel;
		hostBlue = blue;
		@(negedge iCLK);
		curH = scanPos[19:10];
		curV = scanPos[9:0];
	endtask

	task automatic compare(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		checks++;
		if (expVal !== actVal)
		begin
			errors++;
			$display("Mismatch %s: expected 0x%0h, actual 0x%0h at h=%0d v=%0d",
				name, expVal, actVal, curH, curV);
		end
	endtask

	// two outermost columns and rows of the frame box
	function automatic logic onFrame(input int h, input int v);
		logic inBox;
		inBox = h >= FRAME_L && h <= FRAME_R && v >= FRAME_T && v <= FRAME_B;
		return inBox && (h <= FRAME_L + 1 || h >= FRAME_R - 1 ||
			v <= FRAME_T + 1 || v >= FRAME_B - 1);
	endfunction

	function automatic logic [9:0] expectedLevel(input int h, input int v, input logic [4:0] drawn,
		input logic [9:0] blue);
		logic hit;
		logic inWin;
		int   l;
		hit = onFrame(h, v);
		for (int i = 0; i < 5; i++)
		begin
			l = RECT_X[i];
			// bit 4 is rectangle 1
			if (drawn[4 - i] && h >= l && h <= l + RECT_W && v >= RECT_T && v <= RECT_B &&
				(h == l || h == l + RECT_W || v == RECT_T || v == RECT_B))
				hit = 1'b1;
		end
		inWin = h >= X0 && h < X0 + H_ACT && v >= Y0 && v < Y0 + V_ACT;
		if (hit)
			return OVERLAY;
		else if (inWin && blue > THRESHOLD)
			return WHITE;
		else
			return 10'h000;
	endfunction

	function automatic logic [4:0] drawnFor(input logic [4:0] sel);
		logic [4:0] drawn;
		drawn = 5'b00000;
		for (int i = 0; i < 5; i++)
			if (SEL_IN[i] == sel)
				drawn = SEL_DRAWN[i];
		return drawn;
	endfunction

	// all three channels against the model using this cycle's inputs
	task automatic checkColor;
		logic [9:0] expVal;
		expVal = expectedLevel(curH, curV, drawnFor(rectSel), hostBlue);
		compare("vgaColor.r", expVal, vgaColor[29:20]);
		compare("vgaColor.g", expVal, vgaColor[19:10]);
		compare("vgaColor.b", expVal, vgaColor[9:0]);
	endtask

	task automatic checkIdle;
		compare("scanPos", 0, scanPos);
		compare("hSync", 0, hSync);
		compare("vSync", 0, vSync);
		compare("blank", 0, blank);
		compare("request", 0, request);
	endtask

	task automatic resetState;
		@(posedge iCLK);
		@(negedge iCLK);
		checkIdle();
		@(posedge iCLK);
		#1;
		iRST_N = 1'b1;
		// released but no edge has passed yet
		@(negedge iCLK);
		checkIdle();
		curH = scanPos[19:10];
		curV = scanPos[9:0];
	endtask

	task automatic lineFrameTiming;
		logic       wrapped;
		logic       expHSync;
		logic       expVSync;
		logic [9:0] expH;
		logic [9:0] expV;
		wrapped  = 1'b0;
		expVSync = 1'b0;
		// through the vertical wrap and two more lines
		while (!(wrapped && curV == 10'd2))
		begin
			advance(5'b00000, 10'h000);
			expH = (prevH == H_TOTAL) ? 10'd0 : prevH + 10'd1;
			expV = prevV;
			if (prevH == 0)
			begin
				expV = (prevV == V_TOTAL) ? 10'd0 : prevV + 10'd1;
				expVSync = prevV >= V_SYNC_CYC;
			end
			expHSync = prevH >= H_SYNC_CYC;
			compare("hCount", expH, curH);
			compare("vCount", expV, curV);
			compare("hSync", expHSync, hSync);
			compare("vSync", expVSync, vSync);
			compare("blank", expHSync & expVSync, blank);
			if (prevV == V_TOTAL && curV == 0)
				wrapped = 1'b1;
		end
	endtask

	task automatic requestWindow;
		logic expReq;
		int   highs;
		highs = 0;
		// crosses from the blanked rows into the active rows
		while (curV < 10'd40)
		begin
			advance(5'b00000, 10'h000);
			expReq = prevH >= X0 - LEAD && prevH < X0 + H_ACT - LEAD &&
				prevV >= Y0 && prevV < Y0 + V_ACT;
			compare("request", expReq, request);
			if (request)
				highs++;
		end
		if (highs == 0)
		begin
			errors++;
			$display("request never went high in the active rows");
		end
	endtask

	task automatic blueThreshold;
		logic [9:0] blue;
		int         n;
		n = 0;
		while (curV != 10'd50)
			advance(5'b00000, 10'h000);
		// three full lines including the porches
		while (curV <= 10'd52)
		begin
			randomBlue(blue);
			// threshold and one above it at regular spots
			if (n % 8 == 3)
				blue = 10'h180;
			else if (n % 8 == 4)
				blue = 10'h181;
			advance(5'b00000, blue);
			checkColor();
			n++;
		end
	endtask

	task automatic outerFrame;
		logic [9:0] blue;
		while (curV != FRAME_T - 3)
			advance(5'b00000, 10'h000);
		// every pixel from just above to just below the frame
		while (curV <= FRAME_B + 3)
		begin
			randomBlue(blue);
			advance(5'b00000, blue);
			checkColor();
		end
	endtask

	task automatic rectSelection;
		logic [9:0] blue;
		int         idx;
		int         n;
		n = 0;
		// top row lies inside the frame rows already passed so wait for the next frame
		while (curV != 10'd0)
			advance(5'b00000, 10'h000);
		while (curV != RECT_T)
			advance(5'b00000, 10'h000);
		while (curV <= RECT_T + 61)
		begin
			// top row rotates entries per pixel and side rows take one entry per line
			if (curV == RECT_T)
				idx = n % 5;
			else
				idx = curV % 5;
			randomBlue(blue);
			advance(SEL_IN[idx], blue);
			checkColor();
			n++;
		end
	endtask

	initial
	begin
		iRST_N   = 1'b0;
		rectSel  = 5'b00000;
		hostBlue = 10'h000;
		errors   = 0;
		checks   = 0;
		lcgState = 32'd29464;
		curH     = '0;
		curV     = '0;
		prevH    = '0;
		prevV    = '0;
		resetState();
		lineFrameTiming();
		requestWindow();
		blueThreshold();
		outerFrame();
		rectSelection();
		$display("Checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== vgaOverlay.f ====
rtl/vgaPkg.sv
rtl/vgaTiming.sv
rtl/rectOverlay.sv
rtl/pixelCompose.sv
rtl/vgaController.sv
tb/vgaTiming_asserts.sv
tb/vgaControllerTb.sv
